// ==== vtg.f ====
+incdir+verilog
verilog/vtg_cfg_pkg.sv
verilog/vtg_sync_pkg.sv
verilog/vtg_regs.sv
verilog/vtg_chan_timer.sv
verilog/vtg_video_out.sv
verilog/vtg_top.sv
verif/vtg_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run vtg_tb and check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -f vtg.f --top-module vtg_tb -o vtg_sim
	./obj_dir/vtg_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/vtg_testdata.txt ====
# div hpol vpol | h: sync del gate len | v: sync del gate len
# expected: line_clk hsync_clk pixels frame_lines vsync_lines active_lines
0 0 0 3 2 9 19 1 1 4 9 20 4 10 10 2 5
1 1 0 2 1 7 15 0 2 3 8 32 6 8 9 1 4
2 0 1 1 3 11 19 2 0 5 11 60 6 12 12 3 6
0 1 1 0 0 0 3 0 0 0 3 4 1 1 4 1 1

// ==== verif/vtg_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vtg_consts.svh"

module vtg_tb
	import vtg_sync_pkg::*;
;
	localparam int LIMIT = 5000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic wr = 1'b0;
	logic [`VTG_ADDR_W-1:0] waddr = '0;
	logic [`VTG_DATA_W-1:0] wdata = '0;
	logic [`VTG_ADDR_W-1:0] raddr = '0;
	logic [`VTG_DATA_W-1:0] rdata;
	video_out_t vid;

	integer seed = 32'h7ec790be;
	integer errors = 0;
	integer timeouts = 0;
	integer p [0:16];
	logic hpol;
	logic vpol;

	always #4 clk = !clk;

	vtg_top u_vtg_top (
		.clk(clk), .rst(rst), .wr(wr), .waddr(waddr), .wdata(wdata),
		.raddr(raddr), .rdata(rdata), .vid(vid)
	);

	task automatic compare(input integer got, input integer exp, input string what);
		assert (got == exp) else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// write one register, then read it back
	task automatic write_reg(input logic [2:0] addr, input logic [15:0] val);
		logic [15:0] exp;
		exp = (addr == `VTG_REG_CTRL) ? (val & 16'hff07) : val;
		@(posedge clk);
		#1 wr = 1'b1;
		waddr = addr;
		wdata = val;
		@(posedge clk);
		#1 wr = 1'b0;
		raddr = addr;
		#2 compare(rdata, exp, $sformatf("readback of register %0d", addr));
	endtask

	task automatic wait_sync(input bit vert, input logic lvl, input string what,
		output integer clocks);
		clocks = 0;
		while ((vert ? vid.vsync : vid.hsync) != lvl && clocks < LIMIT)
		begin
			@(negedge clk);
			clocks++;
		end
		if (clocks >= LIMIT)
		begin
			timeouts++;
			$display("timeout: %s never arrived", what);
		end
	endtask

	task automatic measure();
		integer hs_clk, gap, vs_clk, frame_clk, act, blank_clk, le_cnt, fe_cnt, max_x, n;
		logic prev_v, prev_b;
		wait_sync(0, hpol, "hsync idle level", n);
		wait_sync(0, !hpol, "hsync start", n);
		wait_sync(0, hpol, "hsync end", hs_clk);
		wait_sync(0, !hpol, "next hsync start", gap);
		compare(hs_clk, p[12], "hsync width in clocks");
		compare(hs_clk + gap, p[11], "line period in clocks");
		wait_sync(1, vpol, "vsync idle level", n);
		wait_sync(1, !vpol, "vsync start", n);
		vs_clk = 0;
		frame_clk = 0;
		act = 0;
		blank_clk = 0;
		le_cnt = 0;
		fe_cnt = 0;
		max_x = 0;
		prev_b = 1'b1;
		prev_v = vpol;
		// one frame from vsync start up to the next vsync start
		while (!(vid.vsync == !vpol && prev_v == vpol && frame_clk > 0) && frame_clk < LIMIT)
		begin
			if (vid.vsync == !vpol)
				vs_clk++;
			if (!vid.blank)
			begin
				blank_clk++;
				if (vid.x > max_x)
					max_x = vid.x;
				if (prev_b)
				begin
					act++;
					compare(vid.x, 0, "x at start of active line");
					compare(vid.y, act - 1, "y at start of active line");
				end
			end
			le_cnt += vid.line_end;
			// the pulse at the opening vsync belongs to the previous frame
			if (frame_clk > 0)
				fe_cnt += vid.frame_end;
			prev_b = vid.blank;
			prev_v = vid.vsync;
			@(negedge clk);
			frame_clk++;
		end
		if (frame_clk >= LIMIT)
		begin
			timeouts++;
			$display("timeout: end of frame never arrived");
			return;
		end
		// frame_end of this frame comes with the next vsync start
		fe_cnt += vid.frame_end;
		compare(frame_clk, p[14] * p[11], "frame period in clocks");
		compare(vs_clk, p[15] * p[11], "vsync width in clocks");
		compare(act, p[16], "active lines");
		compare(blank_clk, p[13] * (p[0] + 1) * p[16], "active clocks per frame");
		compare(max_x, p[5], "last x of a line");
		compare(le_cnt, p[14], "line_end pulses per frame");
		compare(fe_cnt, 1, "frame_end pulses per frame");
	endtask

	task automatic check_idle();
		repeat (3) @(posedge clk);
		#1;
		compare(vid.hsync, hpol, "idle hsync level");
		compare(vid.vsync, vpol, "idle vsync level");
		compare(vid.blank, 1, "idle blank");
		compare(vid.line_end + vid.frame_end, 0, "idle flags");
	endtask

	task automatic run_case();
		integer ord [1:6];
		integer j, k, t;
		logic [15:0] ctrl_off;
		// expected values from the timing rules
		compare(p[11], (p[6] + 1) * (p[0] + 1), "data file line clocks");
		compare(p[12], (p[3] + 1) * (p[0] + 1), "data file hsync clocks");
		compare(p[13], p[5] + 1, "data file pixels");
		compare(p[14], p[10] + 1, "data file frame lines");
		compare(p[15], p[7] + 1, "data file vsync lines");
		compare(p[16], p[9] + 1, "data file active lines");
		hpol = p[1][0];
		vpol = p[2][0];
		ctrl_off = {p[0][7:0], 5'd0, vpol, hpol, 1'b0};
		write_reg(`VTG_REG_CTRL, $random(seed) & 16'hff06);
		for (j = 1; j <= 6; j++)
		begin
			write_reg(j, $random(seed));
			ord[j] = j;
		end
		for (j = 6; j > 1; j--)
		begin
			k = 1 + ({$random(seed)} % j);
			t = ord[j];
			ord[j] = ord[k];
			ord[k] = t;
		end
		write_reg(`VTG_REG_CTRL, ctrl_off);
		for (j = 1; j <= 6; j++)
		begin
			case (ord[j])
				1: write_reg(`VTG_REG_HSD, {p[4][7:0], p[3][7:0]});
				2: write_reg(`VTG_REG_HGATE, p[5]);
				3: write_reg(`VTG_REG_HLEN, p[6]);
				4: write_reg(`VTG_REG_VSD, {p[8][7:0], p[7][7:0]});
				5: write_reg(`VTG_REG_VGATE, p[9]);
				default: write_reg(`VTG_REG_VLEN, p[10]);
			endcase
		end
		check_idle();
		write_reg(`VTG_REG_CTRL, ctrl_off | 16'h1);
		measure();
		write_reg(`VTG_REG_CTRL, ctrl_off);
		check_idle();
		write_reg(`VTG_REG_CTRL, ctrl_off | 16'h1);
		measure();
		write_reg(`VTG_REG_CTRL, ctrl_off);
	endtask

	initial
	begin
		integer fd, cnt;
		string line;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		fd = $fopen("verif/vtg_testdata.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the test data file");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				cnt = $fgets(line, fd);
				if (cnt > 0 && line.len() > 1 && line[0] != "#")
				begin
					cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
						p[0], p[1], p[2], p[3], p[4], p[5], p[6], p[7], p[8], p[9], p[10],
						p[11], p[12], p[13], p[14], p[15], p[16]);
					if (cnt == 17)
						run_case();
				end
			end
			$fclose(fd);
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/vtg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vtg_consts.svh"

module vtg_top
	import vtg_cfg_pkg::*;
	import vtg_sync_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  logic [`VTG_ADDR_W-1:0] waddr,
	input  logic [`VTG_DATA_W-1:0] wdata,
	input  logic [`VTG_ADDR_W-1:0] raddr,
	output logic [`VTG_DATA_W-1:0] rdata,
	output video_out_t vid
);

	vtg_ctrl_t ctrl;
	chan_timing_t [`VTG_NCHAN-1:0] timing;
	chan_status_t [`VTG_NCHAN-1:0] status;
	logic pix_stb;
	logic tim_clr;

	vtg_regs u_regs (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.waddr(waddr),
		.wdata(wdata),
		.raddr(raddr),
		.rdata(rdata),
		.ctrl(ctrl),
		.timing(timing),
		.pix_stb(pix_stb),
		.tim_clr(tim_clr)
	);

	// ============================================================
	// channel timers, each one steps on the period end of the previous
	// ============================================================
	genvar i;
	generate
		for (i = 0; i < `VTG_NCHAN; i++)
		begin : u_chan
			vtg_chan_timer u_timer (
				.clk(clk),
				.rst(tim_clr),
				.ena(pix_stb && (i == 0 || status[(i > 0) ? i - 1 : 0].done)),
				.timing(timing[i]),
				.status(status[i])
			);
		end
	endgenerate

	vtg_video_out u_video_out (
		.clk(clk),
		.rst(rst),
		.pix_stb(pix_stb),
		.ctrl(ctrl),
		.status(status),
		.vid(vid)
	);

endmodule

`default_nettype wire

// ==== verilog/vtg_video_out.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vtg_consts.svh"

module vtg_video_out
	import vtg_cfg_pkg::*;
	import vtg_sync_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic pix_stb,
	input  vtg_ctrl_t ctrl,
	input  chan_status_t [`VTG_NCHAN-1:0] status,
	output video_out_t vid
);

	chan_status_t hst;
	chan_status_t vst;
	logic [`VTG_DATA_W-1:0] x_cnt;
	logic [`VTG_DATA_W-1:0] y_cnt;
	logic hgate_d;
	logic vdone_d;
	logic hgate_fall;
	logic vdone_rise;

	assign hst = status[0];
	assign vst = status[1];

	// edges of the timer levels
	assign hgate_fall = hgate_d && !hst.gate;
	assign vdone_rise = vst.done && !vdone_d;

	// ============================================================
	// position counters
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst || !ctrl.enable)
		begin
			x_cnt <= '0;
			y_cnt <= '0;
			hgate_d <= 1'b0;
			vdone_d <= 1'b0;
		end
		else
		begin
			hgate_d <= hst.gate;
			vdone_d <= vst.done;

			// pixel index within the active part of a line
			if (!hst.gate)
				x_cnt <= '0;
			else if (pix_stb)
				x_cnt <= x_cnt + 1'b1;

			// line index, restarts with vertical sync
			if (vst.sync)
				y_cnt <= '0;
			else if (vst.gate && hgate_fall)
				y_cnt <= y_cnt + 1'b1;
		end
	end

	// ============================================================
	// registered outputs
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vid <= '0;
			vid.blank <= 1'b1;
		end
		else
		begin
			vid.hsync <= hst.sync ^ ctrl.hpol;
			vid.vsync <= vst.sync ^ ctrl.vpol;
			vid.blank <= !(hst.gate && vst.gate);
			vid.x <= hst.gate ? x_cnt : '0;
			vid.y <= y_cnt;
			// gate end of every line
			vid.line_end <= ctrl.enable && hgate_fall;
			vid.frame_end <= ctrl.enable && vdone_rise;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/vtg_chan_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vtg_consts.svh"

module vtg_chan_timer
	import vtg_cfg_pkg::*;
	import vtg_sync_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic ena,
	input  chan_timing_t timing,
	output chan_status_t status
);

	localparam int CW = `VTG_DATA_W;

	// one-hot states
	localparam logic [4:0] ST_IDLE = 5'b00001;
	localparam logic [4:0] ST_SYNC = 5'b00010;
	localparam logic [4:0] ST_GDEL = 5'b00100;
	localparam logic [4:0] ST_GATE = 5'b01000;
	localparam logic [4:0] ST_LEN = 5'b10000;

	logic [4:0] state;
	logic [CW-1:0] seg_cnt;
	logic [CW-1:0] len_cnt;
	logic [CW:0] seg_nxt;
	logic [CW:0] len_nxt;
	logic seg_done;
	logic len_done;

	// expiry is the borrow out of the decrement
	assign seg_nxt = {1'b0, seg_cnt} - 1'b1;
	assign len_nxt = {1'b0, len_cnt} - 1'b1;
	assign seg_done = seg_nxt[CW];
	assign len_done = len_nxt[CW];

	// ============================================================
	// segment counters
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (ena)
		begin
			seg_cnt <= seg_nxt[CW-1:0];
			len_cnt <= len_nxt[CW-1:0];
			if (state[0] || (state[4] && len_done))
			begin
				seg_cnt <= CW'(timing.tsync);
				len_cnt <= timing.tlen;
			end
			else if (state[1] && seg_done)
				seg_cnt <= CW'(timing.tgdel);
			else if (state[2] && seg_done)
				seg_cnt <= timing.tgate;
		end
	end

	// ============================================================
	// state machine
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			status <= '0;
		end
		else if (ena)
		begin
			status.done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					state <= ST_SYNC;
					status.sync <= 1'b1;
				end
				ST_SYNC:
					if (seg_done)
					begin
						state <= ST_GDEL;
						status.sync <= 1'b0;
					end
				ST_GDEL:
					if (seg_done)
					begin
						state <= ST_GATE;
						status.gate <= 1'b1;
					end
				ST_GATE:
					if (seg_done)
					begin
						state <= ST_LEN;
						status.gate <= 1'b0;
					end
				ST_LEN:
					if (len_done)
					begin
						// new period starts with sync
						state <= ST_SYNC;
						status.sync <= 1'b1;
						status.done <= 1'b1;
					end
				default:
				begin
					state <= ST_IDLE;
					status <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/vtg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vtg_consts.svh"

module vtg_regs
	import vtg_cfg_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  logic [`VTG_ADDR_W-1:0] waddr,
	input  logic [`VTG_DATA_W-1:0] wdata,
	input  logic [`VTG_ADDR_W-1:0] raddr,
	output logic [`VTG_DATA_W-1:0] rdata,
	output vtg_ctrl_t ctrl,
	output chan_timing_t [`VTG_NCHAN-1:0] timing,
	output logic pix_stb,
	output logic tim_clr
);

	logic [`VTG_DIV_W-1:0] div_cnt;
	logic [`VTG_DATA_W-1:0] ctrl_word;

	// ============================================================
	// register writes
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst)
			ctrl <= '0;
		else if (wr && waddr == `VTG_REG_CTRL)
		begin
			ctrl.enable <= wdata[`VTG_CTRL_EN];
			ctrl.hpol <= wdata[`VTG_CTRL_HPOL];
			ctrl.vpol <= wdata[`VTG_CTRL_VPOL];
			ctrl.div <= wdata[`VTG_CTRL_DIV +: `VTG_DIV_W];
		end
	end

	// timing words, sync in the low byte and delay in the high byte
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			case (waddr)
				`VTG_REG_HSD: {timing[0].tgdel, timing[0].tsync} <= wdata;
				`VTG_REG_HGATE: timing[0].tgate <= wdata;
				`VTG_REG_HLEN: timing[0].tlen <= wdata;
				`VTG_REG_VSD: {timing[1].tgdel, timing[1].tsync} <= wdata;
				`VTG_REG_VGATE: timing[1].tgate <= wdata;
				`VTG_REG_VLEN: timing[1].tlen <= wdata;
				default: ;
			endcase
		end
	end

	// ============================================================
	// readback
	// ============================================================
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[`VTG_CTRL_EN] = ctrl.enable;
		ctrl_word[`VTG_CTRL_HPOL] = ctrl.hpol;
		ctrl_word[`VTG_CTRL_VPOL] = ctrl.vpol;
		ctrl_word[`VTG_CTRL_DIV +: `VTG_DIV_W] = ctrl.div;
	end

	always_comb
	begin
		case (raddr)
			`VTG_REG_CTRL: rdata = ctrl_word;
			`VTG_REG_HSD: rdata = {timing[0].tgdel, timing[0].tsync};
			`VTG_REG_HGATE: rdata = timing[0].tgate;
			`VTG_REG_HLEN: rdata = timing[0].tlen;
			`VTG_REG_VSD: rdata = {timing[1].tgdel, timing[1].tsync};
			`VTG_REG_VGATE: rdata = timing[1].tgate;
			`VTG_REG_VLEN: rdata = timing[1].tlen;
			default: rdata = '0;
		endcase
	end

	// ============================================================
	// pixel strobe and timer clear
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst || !ctrl.enable)
		begin
			div_cnt <= '0;
			pix_stb <= 1'b0;
		end
		else if (div_cnt == ctrl.div)
		begin
			div_cnt <= '0;
			pix_stb <= 1'b1;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
			pix_stb <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			tim_clr <= 1'b1;
		else
			tim_clr <= !ctrl.enable;
	end

endmodule

`default_nettype wire

// ==== verilog/vtg_sync_pkg.sv ====
`default_nettype none

`include "vtg_consts.svh"

package vtg_sync_pkg;

	// levels from one channel timer
	typedef struct packed {
		logic sync;
		logic gate;
		// first enabled cycle of a new period
		logic done;
	} chan_status_t;

	// registered video outputs
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
		logic line_end;
		logic frame_end;
		logic [`VTG_DATA_W-1:0] x;
		logic [`VTG_DATA_W-1:0] y;
	} video_out_t;

endpackage

`default_nettype wire

// ==== verilog/vtg_cfg_pkg.sv ====
`default_nettype none

`include "vtg_consts.svh"

package vtg_cfg_pkg;

	// ============================================================
	// channel timing, all values are counts minus one
	// ============================================================
	typedef struct packed {
		logic [`VTG_SYNC_W-1:0] tsync;
		logic [`VTG_SYNC_W-1:0] tgdel;
		logic [`VTG_DATA_W-1:0] tgate;
		logic [`VTG_DATA_W-1:0] tlen;
	} chan_timing_t;

	// ============================================================
	// global control
	// ============================================================
	typedef struct packed {
		logic enable;
		// sync polarity, 1 inverts
		logic hpol;
		logic vpol;
		// pixel strobe every div+1 clocks
		logic [`VTG_DIV_W-1:0] div;
	} vtg_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/vtg_consts.svh ====
`ifndef VTG_CONSTS_SVH
`define VTG_CONSTS_SVH

// channel count, 0 is horizontal and 1 is vertical
`define VTG_NCHAN 2

`define VTG_ADDR_W 3
`define VTG_DATA_W 16
`define VTG_SYNC_W 8
`define VTG_DIV_W 8

// register map
`define VTG_REG_CTRL  3'd0
`define VTG_REG_HSD   3'd1
`define VTG_REG_HGATE 3'd2
`define VTG_REG_HLEN  3'd3
`define VTG_REG_VSD   3'd4
`define VTG_REG_VGATE 3'd5
`define VTG_REG_VLEN  3'd6

// control word bit positions, div sits in the upper byte
`define VTG_CTRL_EN   0
`define VTG_CTRL_HPOL 1
`define VTG_CTRL_VPOL 2
`define VTG_CTRL_DIV  8

`endif
